// ==== smc_defines.svh ====
//--------------------------------------
// Widths and external timing counts for the static memory controller
// Include wherever a width or timing count is needed
//--------------------------------------
`ifndef SMC_DEFINES_SVH
`define SMC_DEFINES_SVH

// AHB-lite side
`define SMC_ADDR_W 32   // AHB address width
`define SMC_DATA_W 32   // AHB data width

// External memory bus
`define SMC_EMI_W  16   // External data width
`define SMC_EMI_AW 20   // External byte address width

//--------------------------------------
// Beat timing in hclk cycles
// All three counts must be at least 1
`define SMC_CSLE   1    // Chip select to strobe lead
`define SMC_WS     2    // Strobe length (wait states plus one)
`define SMC_CSTE   1    // Strobe end to chip select release

`endif

// ==== smc_pkg.sv ====
//--------------------------------------
// Shared types for the static memory controller
// Compile ahead of every controller module
//--------------------------------------
`default_nettype none
`include "smc_defines.svh"

package smc_pkg;

  // AHB transfer size, low two bits of hsize
  typedef logic [1:0] size_t;
  localparam size_t SZ_BYTE = 2'b00;
  localparam size_t SZ_HALF = 2'b01;
  localparam size_t SZ_WORD = 2'b10;

  // One accepted AHB transfer with its data phase write data
  typedef struct packed {
    logic [`SMC_ADDR_W-1:0] addr;   // Byte address
    logic                   write;  // High for a write
    size_t                  size;
    logic [`SMC_DATA_W-1:0] wdata;  // All four lanes as on hwdata
  } access_t;

  // One 16-bit external access
  typedef struct packed {
    logic [`SMC_EMI_AW-1:0] addr;   // Halfword aligned byte address
    logic [1:0]             n_be;   // Byte enables, active low
    logic                   write;
    logic [`SMC_EMI_W-1:0]  wdata;  // Half that goes on the pins
    logic                   last;   // Final beat of its transfer
  } beat_t;

  // External memory output pins
  typedef struct packed {
    logic [`SMC_EMI_AW-1:0] addr;
    logic [`SMC_EMI_W-1:0]  data;
    logic [1:0]             n_be;
    logic                   n_cs;
    logic                   n_rd;
    logic [1:0]             n_we;   // Per byte write strobes
    logic                   n_oe;   // Write data driver enable
  } emi_t;

  // Beat phases
  typedef enum logic [1:0] {IDLE, LEAD, STROBE, TRAIL} beat_state_t;

endpackage

`default_nettype wire

// ==== smc_ahb_slave.sv ====
//--------------------------------------
// AHB-lite slave of the memory controller
// Captures each transfer and stalls the bus until its beats are done
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module smc_ahb_slave (
  input  logic                   hclk,
  input  logic                   rst_n,
  input  logic                   hsel,
  input  logic [`SMC_ADDR_W-1:0] haddr,
  input  logic [1:0]             htrans,
  input  logic                   hwrite,
  input  smc_pkg::size_t         hsize,
  input  logic [`SMC_DATA_W-1:0] hwdata,
  input  logic                   hready,      // Muxed ready from the bus
  input  logic                   mac_done,    // Last beat finished
  input  logic [`SMC_DATA_W-1:0] rdata,       // Assembled read data
  output logic                   smc_hready,
  output logic [`SMC_DATA_W-1:0] smc_hrdata,
  output logic                   new_access,  // One cycle pulse in data phase
  output smc_pkg::access_t       access
);

  logic                   accept;    // Valid address phase this cycle
  logic                   dphase_q;  // Data phase of an accepted transfer
  logic [`SMC_ADDR_W-1:0] addr_q;
  logic                   write_q;
  smc_pkg::size_t         size_q;

  //--------------------------------------
  // Address phase
  //--------------------------------------
  // NONSEQ and SEQ both have htrans[1] set
  assign accept = hsel & htrans[1] & hready;

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      dphase_q <= 1'b0;
    end else begin
      dphase_q <= accept;
    end
  end

  // Control of the address phase, held for the data phase
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= haddr;
      write_q <= hwrite;
      size_q  <= hsize;
    end
  end

  //--------------------------------------
  // Data phase
  //--------------------------------------
  // hwdata is only valid now, so the access is built here
  assign new_access = dphase_q;
  assign access     = '{addr:  addr_q,
                        write: write_q,
                        size:  size_q,
                        wdata: hwdata};

  // Low from the data phase until the last beat completes
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      smc_hready <= 1'b1;
    end else if (accept) begin
      smc_hready <= 1'b0;
    end else if (mac_done) begin
      smc_hready <= 1'b1;
    end
  end

  // Read data lines up with the rising smc_hready
  always_ff @(posedge hclk) begin
    if (mac_done) begin
      smc_hrdata <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== smc_access_split.sv ====
//--------------------------------------
// Multiple access control
// Splits one transfer into 16-bit beats and gathers the read halves
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module smc_access_split (
  input  logic                   hclk,
  input  logic                   rst_n,
  input  logic                   new_access,
  input  smc_pkg::access_t       access,
  input  logic                   beat_done,   // Last cycle of a beat
  input  logic                   sample_rd,   // data_smc valid this cycle
  input  logic [`SMC_EMI_W-1:0]  data_smc,
  output logic                   beat_valid,
  output smc_pkg::beat_t         beat,
  output logic                   mac_done,
  output logic [`SMC_DATA_W-1:0] rdata
);

  smc_pkg::access_t       acc_q;      // Transfer in progress
  smc_pkg::access_t       src;        // Transfer the current beat comes from
  logic                   idx_q;      // Beat number within the transfer
  logic                   idx;
  logic                   half_sel;   // Upper half of the word
  logic                   pend_q;     // Second beat of a word waiting
  logic                   mac_done_q;
  logic [7:0]             rd_byte;    // Addressed byte of the read half
  logic [`SMC_DATA_W-1:0] rdata_q;

  //--------------------------------------
  // Beat request
  //--------------------------------------
  // First beat goes out in the same cycle as new_access
  assign src        = new_access ? access : acc_q;
  assign idx        = new_access ? 1'b0 : idx_q;
  assign half_sel   = src.addr[1] | idx;  // Beat 0 is the low half
  assign beat_valid = new_access | pend_q;

  always_comb begin
    beat.addr  = {src.addr[`SMC_EMI_AW-1:2], half_sel, 1'b0};
    beat.write = src.write;
    beat.wdata = half_sel ? src.wdata[`SMC_DATA_W-1:`SMC_EMI_W]
                          : src.wdata[`SMC_EMI_W-1:0];
    // A byte enables only its own lane
    if (src.size == smc_pkg::SZ_BYTE) begin
      beat.n_be = src.addr[0] ? 2'b01 : 2'b10;
    end else begin
      beat.n_be = 2'b00;
    end
    beat.last  = (src.size != smc_pkg::SZ_WORD) | idx;  // Word needs two beats
  end

  //--------------------------------------
  // Beat count
  //--------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q      <= 1'b0;
      pend_q     <= 1'b0;
      mac_done_q <= 1'b0;
    end else begin
      pend_q     <= beat_done & ~beat.last;   // Next beat one cycle later
      mac_done_q <= beat_done & beat.last;
      if (new_access) begin
        idx_q <= 1'b0;
      end else if (beat_done & ~beat.last) begin
        idx_q <= 1'b1;
      end
    end
  end

  //--------------------------------------
  // Transfer store and read assembly
  //--------------------------------------
  assign rd_byte = acc_q.addr[0] ? data_smc[15:8] : data_smc[7:0];

  always_ff @(posedge hclk) begin
    if (new_access) begin
      acc_q <= access;
    end
    if (sample_rd) begin
      case (acc_q.size)
        smc_pkg::SZ_BYTE: rdata_q <= {4{rd_byte}};   // Copy to every lane
        smc_pkg::SZ_HALF: rdata_q <= {2{data_smc}};
        default:          rdata_q[`SMC_EMI_W*idx_q +: `SMC_EMI_W] <= data_smc;
      endcase
    end
  end

  assign mac_done = mac_done_q;
  assign rdata    = rdata_q;

endmodule

`default_nettype wire

// ==== smc_beat_fsm.sv ====
//--------------------------------------
// External access FSM
// Times each beat as chip select lead, strobe and trail phases
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module smc_beat_fsm (
  input  logic                 hclk,
  input  logic                 rst_n,
  input  logic                 beat_valid,
  input  smc_pkg::beat_t       beat,
  output logic                 beat_done,  // Last trail cycle
  output logic                 sample_rd,  // Last strobe cycle at the pins
  output smc_pkg::beat_state_t state,
  output smc_pkg::beat_t       cur_beat
);

  localparam int CNT_W = 8;

  // Reload values, counted down to zero
  localparam logic [CNT_W-1:0] LEAD_CNT   = CNT_W'(`SMC_CSLE - 1);
  localparam logic [CNT_W-1:0] STROBE_CNT = CNT_W'(`SMC_WS - 1);
  localparam logic [CNT_W-1:0] TRAIL_CNT  = CNT_W'(`SMC_CSTE - 1);

  smc_pkg::beat_state_t state_q;
  logic [CNT_W-1:0]     cnt_q;       // Single phase counter
  logic                 cnt_zero;
  logic                 beat_start;  // Beat loaded this cycle
  logic                 strobe_last;
  logic                 sample_q;
  smc_pkg::beat_t       beat_q;

  assign cnt_zero    = (cnt_q == '0);
  assign beat_start  = (state_q == smc_pkg::IDLE) & beat_valid;
  assign strobe_last = (state_q == smc_pkg::STROBE) & cnt_zero;
  assign beat_done   = (state_q == smc_pkg::TRAIL) & cnt_zero;

  //--------------------------------------
  // Phase sequencing
  //--------------------------------------
  // IDLE always lasts a cycle, so chip select goes high between beats
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= smc_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        smc_pkg::IDLE: begin
          if (beat_start) begin
            state_q <= smc_pkg::LEAD;
            cnt_q   <= LEAD_CNT;
          end
        end
        smc_pkg::LEAD: begin
          if (cnt_zero) begin
            state_q <= smc_pkg::STROBE;
            cnt_q   <= STROBE_CNT;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        smc_pkg::STROBE: begin
          if (cnt_zero) begin
            state_q <= smc_pkg::TRAIL;
            cnt_q   <= TRAIL_CNT;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        smc_pkg::TRAIL: begin
          if (cnt_zero) begin
            state_q <= smc_pkg::IDLE;   // Beat over
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          state_q <= smc_pkg::IDLE;
        end
      endcase
    end
  end

  //--------------------------------------
  // Read sample point
  //--------------------------------------
  // Pins lag the state by one register, so the marker is delayed to match
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      sample_q <= 1'b0;
    end else begin
      sample_q <= strobe_last & ~beat_q.write;
    end
  end

  // Beat held for the whole of its phases
  always_ff @(posedge hclk) begin
    if (beat_start) begin
      beat_q <= beat;
    end
  end

  assign sample_rd = sample_q;
  assign state     = state_q;
  assign cur_beat  = beat_q;

endmodule

`default_nettype wire

// ==== smc_strobe_gen.sv ====
//--------------------------------------
// Strobe generation for the external pins
// Every pin leaves a flop, so strobes are glitch-free
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module smc_strobe_gen (
  input  logic                 hclk,
  input  logic                 rst_n,
  input  smc_pkg::beat_state_t state,
  input  smc_pkg::beat_t       cur_beat,
  output smc_pkg::emi_t        emi
);

  logic                   active;   // Any phase of a beat
  logic                   strobe;
  logic                   n_cs_q;
  logic                   n_rd_q;
  logic [1:0]             n_we_q;
  logic                   n_oe_q;
  logic [1:0]             n_be_q;
  logic [`SMC_EMI_AW-1:0] addr_q;
  logic [`SMC_EMI_W-1:0]  data_q;

  assign active = (state != smc_pkg::IDLE);
  assign strobe = (state == smc_pkg::STROBE);

  //--------------------------------------
  // Control pins, all idle high
  //--------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      n_cs_q <= 1'b1;
      n_rd_q <= 1'b1;
      n_we_q <= 2'b11;
      n_oe_q <= 1'b1;
      n_be_q <= 2'b11;
    end else begin
      n_cs_q <= ~active;
      n_rd_q <= ~(strobe & ~cur_beat.write);
      n_we_q <= (strobe & cur_beat.write) ? cur_beat.n_be : 2'b11;  // Per byte
      n_oe_q <= ~(active & cur_beat.write);  // Drive data over the whole write
      n_be_q <= active ? cur_beat.n_be : 2'b11;
    end
  end

  // Address and write data, steady past the rising n_we
  always_ff @(posedge hclk) begin
    addr_q <= cur_beat.addr;
    data_q <= cur_beat.wdata;
  end

  assign emi = '{addr: addr_q,
                 data: data_q,
                 n_be: n_be_q,
                 n_cs: n_cs_q,
                 n_rd: n_rd_q,
                 n_we: n_we_q,
                 n_oe: n_oe_q};

endmodule

`default_nettype wire

// ==== smc_top.sv ====
//--------------------------------------
// Static memory controller top level
// AHB-lite slave in front of one 16-bit SRAM bank
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module smc_top (
  input  logic                   hclk,
  input  logic                   rst_n,
  input  logic                   hsel,
  input  logic [`SMC_ADDR_W-1:0] haddr,
  input  logic [1:0]             htrans,
  input  logic                   hwrite,
  input  smc_pkg::size_t         hsize,
  input  logic [`SMC_DATA_W-1:0] hwdata,
  input  logic                   hready,
  input  logic [`SMC_EMI_W-1:0]  data_smc,   // Read data from the memory
  output logic                   smc_hready,
  output logic [`SMC_DATA_W-1:0] smc_hrdata,
  output smc_pkg::emi_t          emi
);

  logic                   new_access;
  smc_pkg::access_t       access;
  logic                   mac_done;
  logic [`SMC_DATA_W-1:0] rdata;
  logic                   beat_valid;
  smc_pkg::beat_t         beat;
  logic                   beat_done;
  logic                   sample_rd;
  smc_pkg::beat_state_t   state;
  smc_pkg::beat_t         cur_beat;

  smc_ahb_slave u_ahb_slave (
    .hclk, .rst_n, .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata, .hready,
    .mac_done, .rdata, .smc_hready, .smc_hrdata, .new_access, .access
  );

  smc_access_split u_access_split (
    .hclk, .rst_n, .new_access, .access, .beat_done, .sample_rd, .data_smc,
    .beat_valid, .beat, .mac_done, .rdata
  );

  smc_beat_fsm u_beat_fsm (
    .hclk, .rst_n, .beat_valid, .beat, .beat_done, .sample_rd, .state, .cur_beat
  );

  smc_strobe_gen u_strobe_gen (
    .hclk, .rst_n, .state, .cur_beat, .emi
  );

endmodule

`default_nettype wire

// ==== tb_smc_checker.sv ====
//--------------------------------------
// Checker for the memory controller testbench
// Follows AHB transfers and SRAM pins against a byte model
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module tb_smc_checker (
  input  logic                   hclk,
  input  logic                   rst_n,
  input  logic                   hsel,
  input  logic [`SMC_ADDR_W-1:0] haddr,
  input  logic [1:0]             htrans,
  input  logic                   hwrite,
  input  smc_pkg::size_t         hsize,
  input  logic [`SMC_DATA_W-1:0] hwdata,
  input  logic                   smc_hready,
  input  logic [`SMC_DATA_W-1:0] smc_hrdata,
  input  smc_pkg::emi_t          emi,
  output int                     errors,
  output int                     xfers
);

  localparam int EAW    = `SMC_EMI_AW;
  localparam int CS_LEN = `SMC_CSLE + `SMC_WS + `SMC_CSTE;

  logic [7:0]     ref_mem [0:63];   // Byte model of the window
  logic           started;          // First transfer accepted
  logic           dphase;           // Transfer waiting for smc_hready
  logic [31:0]    d_addr;
  logic           d_write;
  smc_pkg::size_t d_size;
  int             beats;            // Beats seen for the transfer
  logic           cs_low;           // n_cs at the previous sample
  int             cs_len;
  int             stb_len;
  int             stb_start;        // Cycles from n_cs fall to strobe

  task automatic report_value(input string msg);
    errors++;
    $display("FAIL t=%0t: %s", $time, msg);
  endtask

  task automatic report_other(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic int beat_count(input smc_pkg::size_t sz);
    return (sz == smc_pkg::SZ_WORD) ? 2 : 1;   // Word is two halves
  endfunction

  // Little endian bytes, replicated over the AHB lanes
  function automatic logic [31:0] expect_rd(input logic [31:0] a, input smc_pkg::size_t sz);
    logic [5:0] b;
    b = a[5:0];
    case (sz)
      smc_pkg::SZ_BYTE: return {4{ref_mem[b]}};
      smc_pkg::SZ_HALF: return {2{ref_mem[b + 6'd1], ref_mem[b]}};
      default:          return {ref_mem[b + 6'd3], ref_mem[b + 6'd2],
                                ref_mem[b + 6'd1], ref_mem[b]};
    endcase
  endfunction

  task automatic model_write(input logic [31:0] a, input smc_pkg::size_t sz,
                             input logic [31:0] wd);
    logic [5:0] b;
    for (int k = 0; k < 4; k++) begin
      b = a[5:0] + 6'(k);
      if (k < (1 << int'(sz))) begin   // 1, 2 or 4 bytes
        ref_mem[b] = wd[8 * b[1:0] +: 8];   // Lane follows the byte address
      end
    end
  endtask

  //--------------------------------------
  // Pin checks
  //--------------------------------------
  task automatic check_idle();
    if (!smc_hready || !emi.n_cs || !emi.n_rd || !emi.n_oe || emi.n_we != 2'b11) begin
      report_value($sformatf("idle outputs hready=%b n_cs=%b n_rd=%b n_oe=%b n_we=%b",
                             smc_hready, emi.n_cs, emi.n_rd, emi.n_oe, emi.n_we));
    end
  endtask

  task automatic start_beat();
    logic [EAW-1:0] ea;
    logic [EAW-1:0] off;
    logic [1:0]     eb;
    ea        = {d_addr[EAW-1:1], 1'b0} + EAW'(2 * beats);   // Ascending halves
    // Byte offset of each lane from the transfer start
    for (int j = 0; j < 2; j++) begin
      off   = ea + EAW'(j) - d_addr[EAW-1:0];
      eb[j] = (off >= EAW'(1 << int'(d_size)));   // Lane disabled outside the transfer
    end
    cs_len    = 0;
    stb_len   = 0;
    stb_start = 0;
    if (!dphase) begin
      report_other("chip select fell with no AHB transfer in progress");
    end else if (beats >= beat_count(d_size)) begin
      report_other($sformatf("extra beat for the transfer at %h", d_addr));
    end else begin
      if (emi.addr != ea) report_value($sformatf("beat address %h, expected %h", emi.addr, ea));
      if (emi.n_be != eb) report_value($sformatf("n_be %b, expected %b", emi.n_be, eb));
    end
    beats++;
  endtask

  task automatic watch_pins();
    logic stb;
    stb = !emi.n_rd || (emi.n_we != 2'b11);
    if (!emi.n_cs) begin
      if (!cs_low) start_beat();
      if (d_write ? !emi.n_rd : (emi.n_we != 2'b11)) begin
        report_other("strobe does not match the transfer direction");
      end
      if (stb) begin
        if (stb_len == 0) stb_start = cs_len;
        stb_len++;
      end
      cs_len++;
    end else begin
      if (stb) report_other("strobe low while chip select is high");
      if (cs_low && (cs_len != CS_LEN || stb_len != `SMC_WS || stb_start != `SMC_CSLE)) begin
        report_value($sformatf("n_cs %0d cycles, strobe %0d cycles from cycle %0d",
                               cs_len, stb_len, stb_start));
      end
    end
    cs_low = !emi.n_cs;
  endtask

  task automatic end_xfer();
    logic [31:0] exp;
    if (beats != beat_count(d_size)) begin
      report_other($sformatf("transfer at %h ended after %0d beats", d_addr, beats));
    end
    if (!emi.n_cs) report_other("smc_hready rose while chip select was still low");
    if (d_write) begin
      model_write(d_addr, d_size, hwdata);
    end else begin
      exp = expect_rd(d_addr, d_size);
      if (smc_hrdata !== exp) begin
        report_value($sformatf("read at %h size %0d returned %h, expected %h",
                               d_addr, d_size, smc_hrdata, exp));
      end
    end
    xfers++;
    dphase = 1'b0;
  endtask

  //--------------------------------------
  // Sampling at the falling edge
  //--------------------------------------
  always @(negedge hclk) begin
    if (!rst_n) begin
      errors  = 0;
      xfers   = 0;
      started = 1'b0;
      dphase  = 1'b0;
      d_write = 1'b0;
      beats   = 0;
      cs_low  = 1'b0;
      for (int i = 0; i < 64; i++) begin
        ref_mem[i] = 8'(i) * 8'd37 ^ 8'h5c;   // Same power-up contents as the SRAM
      end
    end else begin
      if (!started) check_idle();
      watch_pins();
      if (dphase && smc_hready) end_xfer();   // Data phase ends this cycle
      if (hsel && htrans[1] && smc_hready) begin
        started = 1'b1;
        dphase  = 1'b1;
        d_addr  = haddr;
        d_write = hwrite;
        d_size  = hsize;
        beats   = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_smc_top.sv ====
//--------------------------------------
// Testbench top for the memory controller
// Random AHB master, SRAM emulation and watchdog around dut0
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "smc_defines.svh"

module tb_smc_top;

  localparam int     N_XFER   = 300;
  localparam int     BEAT_CY  = `SMC_CSLE + `SMC_WS + `SMC_CSTE + 3;  // Beat plus gaps
  localparam longint LIMIT_NS = longint'(N_XFER) * 2 * BEAT_CY * 20 + 20000;

  logic                   hclk = 1'b0;
  logic                   rst_n;
  logic                   hsel;
  logic [`SMC_ADDR_W-1:0] haddr;
  logic [1:0]             htrans;
  logic                   hwrite;
  smc_pkg::size_t         hsize;
  logic [`SMC_DATA_W-1:0] hwdata;
  logic [`SMC_EMI_W-1:0]  data_smc;
  logic                   smc_hready;
  logic [`SMC_DATA_W-1:0] smc_hrdata;
  smc_pkg::emi_t          emi;
  logic                   we_lo;
  logic                   we_hi;
  logic [`SMC_EMI_W-1:0]  sram [0:31];   // 64 byte window
  int                     errors;
  int                     xfers;
  integer                 seed;

  always #10 hclk = ~hclk;   // 20 ns period

  smc_top dut0 (
    .hclk, .rst_n, .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata,
    .hready(smc_hready),    // Only slave on the bus
    .data_smc, .smc_hready, .smc_hrdata, .emi
  );

  tb_smc_checker chk0 (
    .hclk, .rst_n, .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata,
    .smc_hready, .smc_hrdata, .emi, .errors, .xfers
  );

  //--------------------------------------
  // External SRAM emulation
  //--------------------------------------
  assign we_lo    = emi.n_we[0];
  assign we_hi    = emi.n_we[1];
  assign data_smc = emi.n_rd ? '0 : sram[emi.addr[5:1]];   // Driven while n_rd low

  initial begin : sram_model
    for (int i = 0; i < 32; i++) begin
      sram[i] = {8'(2 * i + 1) * 8'd37 ^ 8'h5c, 8'(2 * i) * 8'd37 ^ 8'h5c};
    end
    forever begin
      @(posedge we_lo or posedge we_hi);   // End of a write strobe
      if (rst_n) begin
        if (!emi.n_be[0]) sram[emi.addr[5:1]][7:0] = emi.data[7:0];
        if (!emi.n_be[1]) sram[emi.addr[5:1]][15:8] = emi.data[15:8];
      end
    end
  end

  //--------------------------------------
  // AHB master
  //--------------------------------------
  // Address phase held until accepted, then data phase write data
  task automatic addr_phase(input logic act, input logic wr, input smc_pkg::size_t sz,
                            input logic [31:0] a, input logic [31:0] wd);
    hsel   = act;
    htrans = act ? 2'b10 : 2'b00;   // NONSEQ or IDLE
    hwrite = wr;
    hsize  = sz;
    haddr  = a;
    @(negedge hclk);
    while (!smc_hready) @(negedge hclk);
    @(posedge hclk);
    #2;
    hwdata = (act & wr) ? wd : '0;
  endtask

  task automatic random_xfer();
    logic [31:0]    r;
    logic [31:0]    wd;
    logic [31:0]    a;
    smc_pkg::size_t sz;
    r  = $random(seed);
    wd = $random(seed);
    sz = (r[1:0] == 2'b11) ? smc_pkg::SZ_WORD : r[1:0];
    a  = {26'h0, r[7:2]};
    if (sz == smc_pkg::SZ_WORD) begin
      a[1:0] = 2'b00;
    end else if (sz == smc_pkg::SZ_HALF) begin
      a[0] = 1'b0;
    end
    if (r[10:8] == 3'b000) begin   // Occasional idle cycles
      repeat (1 + r[11]) addr_phase(1'b0, 1'b0, smc_pkg::SZ_BYTE, '0, '0);
    end
    addr_phase(1'b1, r[12], sz, a, wd);
  endtask

  initial begin : stimulus
    seed   = 32'h1744_35c7;
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hsize  = smc_pkg::SZ_BYTE;
    hwdata = '0;
    repeat (3) @(posedge hclk);
    #2;
    rst_n = 1'b1;
    repeat (2) @(posedge hclk);   // Idle outputs get checked here
    #2;
    repeat (N_XFER) random_xfer();
    addr_phase(1'b0, 1'b0, smc_pkg::SZ_BYTE, '0, '0);   // Ends the last data phase
    repeat (4) @(posedge hclk);
    $display("Errors: %0d, transfers completed: %0d of %0d", errors, xfers, N_XFER);
    if (errors == 0 && xfers == N_XFER) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  //--------------------------------------
  // Watchdog
  //--------------------------------------
  initial begin : watchdog
    #(LIMIT_NS);
    $display("Timeout: transfers did not finish within %0d ns", LIMIT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
smc_pkg.sv
smc_ahb_slave.sv
smc_access_split.sv
smc_beat_fsm.sv
smc_strobe_gen.sv
smc_top.sv
tb_smc_checker.sv
tb_smc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_smc_top -o sim_smc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_smc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1
